//--- all.f
+incdir+verif
verilog/sb_pkg.sv
verilog/fu_bus_if.sv
verilog/inst_decoder.sv
verilog/fu_status_entry.sv
verilog/reg_result_status.sv
verilog/issue_ctrl.sv
verilog/fu_arbiter.sv
verilog/scoreboard_top.sv
verif/scoreboard_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := scoreboard_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard verif/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || exit 1

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/scoreboard_tests.svh
`ifndef SCOREBOARD_TESTS_SVH
`define SCOREBOARD_TESTS_SVH

// ADD x3,x1,x2 from issue through write-back
task automatic single_issue();
    apply_reset();
    step(NO_INST, '0, 1'b0);
    check_value("is_en", is_en, 1'b1);
    check_value("fu_en", fu_en, '0);
    check_value("reg_write", reg_write, 1'b0);
    step(add_rr(5'd3, 5'd1, 5'd2), '0, 1'b0);
    check_value("is_en", is_en, 1'b1);
    step(NO_INST, '0, 1'b0);
    check_value("fu_en", fu_en, BIT_ALU);
    check_value("op", op, OP_ALU_ADD);
    check_value("rs1", rs1, 5'd1);
    check_value("rs2", rs2, 5'd2);
    hold(NO_INST, latency(), 1'b0, '1);
    step(NO_INST, BIT_ALU, 1'b0);
    // Done is registered first
    check_value("reg_write", reg_write, 1'b0);
    wait_write(NO_INST, 5'd3, FU_ALU, 1'b0, '1);
endtask

task automatic structural_stall();
    logic [31:0] second;
    second = add_rr(5'd4, 5'd1, 5'd2);
    apply_reset();
    step(add_rr(5'd3, 5'd1, 5'd2), '0, 1'b0);
    step(second, '0, 1'b0);
    check_value("is_en", is_en, 1'b0);
    check_value("fu_en", fu_en, BIT_ALU);
    hold(second, latency(), 1'b1, '1);
    step(second, BIT_ALU, 1'b0);
    check_value("is_en", is_en, 1'b0);
    wait_write(second, 5'd3, FU_ALU, 1'b1, '1);
    // Entry is still busy in its write-back cycle
    check_value("is_en", is_en, 1'b0);
    step(second, '0, 1'b0);
    check_value("is_en", is_en, 1'b1);
    step(NO_INST, '0, 1'b0);
    check_value("fu_en", fu_en, BIT_ALU);
    complete_unit(BIT_ALU, 5'd4, FU_ALU);
endtask

// MUL x5 then DIV x5
task automatic waw_stall();
    logic [31:0] second;
    second = div_rr(5'd5, 5'd3, 5'd4);
    apply_reset();
    step(mul_rr(5'd5, 5'd1, 5'd2), '0, 1'b0);
    step(second, '0, 1'b0);
    check_value("is_en", is_en, 1'b0);
    check_value("fu_en", fu_en, BIT_MUL);
    hold(second, latency(), 1'b1, '1);
    step(second, BIT_MUL, 1'b0);
    check_value("is_en", is_en, 1'b0);
    wait_write(second, 5'd5, FU_MUL, 1'b1, '1);
    // Release frees x5 in the same cycle
    check_value("is_en", is_en, 1'b1);
    step(NO_INST, '0, 1'b0);
    check_value("fu_en", fu_en, BIT_DIV);
    check_value("op", op, OP_DIV_DIV);
    check_value("rs1", rs1, 5'd3);
    check_value("rs2", rs2, 5'd4);
    complete_unit(BIT_DIV, 5'd5, FU_DIV);
endtask

// ADD x6,x5,x1 waits for MUL x5
task automatic raw_wait();
    apply_reset();
    step(mul_rr(5'd5, 5'd1, 5'd2), '0, 1'b0);
    step(add_rr(5'd6, 5'd5, 5'd1), '0, 1'b0);
    check_value("is_en", is_en, 1'b1);
    check_value("fu_en", fu_en, BIT_MUL);
    hold(NO_INST, latency(), 1'b0, BIT_ALU);
    step(NO_INST, BIT_MUL, 1'b0);
    check_value("fu_en", fu_en & BIT_ALU, '0);
    wait_write(NO_INST, 5'd5, FU_MUL, 1'b0, BIT_ALU);
    check_value("fu_en", fu_en, '0);
    step(NO_INST, '0, 1'b0);
    check_value("fu_en", fu_en, BIT_ALU);
    check_value("op", op, OP_ALU_ADD);
    check_value("rs1", rs1, 5'd5);
    check_value("rs2", rs2, 5'd1);
    complete_unit(BIT_ALU, 5'd6, FU_ALU);
endtask

// ADD x1 must not write back before DIV x9,x8,x1 has read x1
task automatic war_hold();
    apply_reset();
    step(lw(5'd8, 5'd2), '0, 1'b0);
    step(div_rr(5'd9, 5'd8, 5'd1), '0, 1'b0);
    check_value("fu_en", fu_en, BIT_MEM);
    step(add_rr(5'd1, 5'd2, 5'd3), '0, 1'b0);
    check_value("is_en", is_en, 1'b1);
    check_value("fu_en", fu_en, '0);
    step(NO_INST, '0, 1'b0);
    check_value("fu_en", fu_en, BIT_ALU);
    hold(NO_INST, latency(), 1'b0, '1);
    step(NO_INST, BIT_ALU, 1'b0);
    repeat (3) begin
        step(NO_INST, '0, 1'b0);
        check_value("reg_write", reg_write, 1'b0);
    end
    step(NO_INST, BIT_MEM, 1'b0);
    check_value("reg_write", reg_write, 1'b0);
    wait_write(NO_INST, 5'd8, FU_MEM, 1'b0, '1);
    step(NO_INST, '0, 1'b0);
    check_value("fu_en", fu_en, BIT_DIV);
    check_value("rs1", rs1, 5'd8);
    check_value("rs2", rs2, 5'd1);
    check_value("reg_write", reg_write, 1'b0);
    wait_write(NO_INST, 5'd1, FU_ALU, 1'b0, '1);
    complete_unit(BIT_DIV, 5'd9, FU_DIV);
endtask

task automatic jump_flush();
    logic [31:0] flushed;
    flushed = add_rr(5'd3, 5'd1, 5'd2);
    apply_reset();
    step(beq(5'd1, 5'd2), '0, 1'b0);
    check_value("is_en", is_en, 1'b1);
    step(flushed, '0, 1'b0);
    check_value("is_en", is_en, 1'b0);
    check_value("fu_en", fu_en, BIT_JUMP);
    check_value("op", op, OP_JUMP_BEQ);
    check_value("rs1", rs1, 5'd1);
    check_value("rs2", rs2, 5'd2);
    hold(flushed, latency(), 1'b1, '1);
    step(flushed, BIT_JUMP, 1'b1);
    check_value("is_en", is_en, 1'b0);
    // Flush cycle, and the branch retires with no destination
    step(flushed, '0, 1'b0);
    check_value("is_en", is_en, 1'b1);
    check_value("reg_write", reg_write, 1'b1);
    check_value("write_sel", write_sel, FU_JUMP);
    step(add_rr(5'd4, 5'd5, 5'd6), '0, 1'b0);
    check_value("is_en", is_en, 1'b1);
    check_value("fu_en", fu_en, '0);
    step(NO_INST, '0, 1'b0);
    check_value("fu_en", fu_en, BIT_ALU);
    check_value("rs1", rs1, 5'd5);
    check_value("rs2", rs2, 5'd6);
    complete_unit(BIT_ALU, 5'd4, FU_ALU);
endtask

`endif

//--- verif/scoreboard_tb.sv
`timescale 1ns/1ns
`default_nettype none

module scoreboard_tb;
    import sb_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    // About 250 cycles of resets and tests, with a fourfold margin
    localparam int RUN_CYCLES   = 250;
    localparam int WATCHDOG_NS  = RUN_CYCLES * CLK_PERIOD * 4;
    localparam int WAIT_LIMIT   = 20;

    // All-zero word has opcode 0, so it never issues
    localparam logic [31:0] NO_INST = 32'h0000_0000;

    // One fu_vec_t bit per unit, ALU in bit 0
    localparam fu_vec_t BIT_ALU  = 5'b00001;
    localparam fu_vec_t BIT_MEM  = 5'b00010;
    localparam fu_vec_t BIT_MUL  = 5'b00100;
    localparam fu_vec_t BIT_DIV  = 5'b01000;
    localparam fu_vec_t BIT_JUMP = 5'b10000;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    fu_vec_t     fu_done;
    logic        is_jump;
    logic        is_en;
    fu_vec_t     fu_en;
    op_t         op;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic        reg_write;
    reg_idx_t    rd;
    fu_id_t      write_sel;

    int errors;
    int checks;

    scoreboard_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .inst      (inst),
        .fu_done   (fu_done),
        .is_jump   (is_jump),
        .is_en     (is_en),
        .fu_en     (fu_en),
        .op        (op),
        .rs1       (rs1),
        .rs2       (rs2),
        .reg_write (reg_write),
        .rd        (rd),
        .write_sel (write_sel)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] add_rr(input reg_idx_t d, input reg_idx_t a,
                                           input reg_idx_t b);
        return {7'h00, b, a, 3'h0, d, OPC_R};
    endfunction

    function automatic logic [31:0] mul_rr(input reg_idx_t d, input reg_idx_t a,
                                           input reg_idx_t b);
        return {7'h01, b, a, 3'h0, d, OPC_R};
    endfunction

    function automatic logic [31:0] div_rr(input reg_idx_t d, input reg_idx_t a,
                                           input reg_idx_t b);
        return {7'h01, b, a, 3'h4, d, OPC_R};
    endfunction

    // LW d, 0(base)
    function automatic logic [31:0] lw(input reg_idx_t d, input reg_idx_t base);
        return {12'h000, base, 3'h2, d, OPC_L};
    endfunction

    function automatic logic [31:0] beq(input reg_idx_t a, input reg_idx_t b);
        return {7'h00, b, a, 3'h0, 5'h00, OPC_B};
    endfunction

    // Unit latency in idle cycles before its done pulse
    function automatic int latency();
        return $urandom_range(4, 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_event(input logic seen, input string what);
        checks++;
        assert (seen) else begin
            errors++;
            $display("ERROR at %0t ns: %s", $time, what);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst     = 1'b1;
        inst    = NO_INST;
        fu_done = '0;
        is_jump = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    // Inputs change on the falling edge, outputs are sampled 1 ns later
    task automatic step(input logic [31:0] i, input fu_vec_t done, input logic jump);
        @(negedge clk);
        inst    = i;
        fu_done = done;
        is_jump = jump;
        #1;
    endtask

    task automatic hold(input logic [31:0] i, input int cycles, input logic stalled,
                        input fu_vec_t quiet);
        repeat (cycles) begin
            step(i, '0, 1'b0);
            if (stalled) begin
                check_value("is_en", is_en, 1'b0);
            end
            check_value("fu_en", fu_en & quiet, '0);
        end
    endtask

    // Steps until reg_write shows up, then checks the write port
    task automatic wait_write(input logic [31:0] i, input reg_idx_t exp_rd,
                              input fu_id_t exp_sel, input logic stalled,
                              input fu_vec_t quiet);
        int n;
        n = 0;
        step(i, '0, 1'b0);
        while (!reg_write && n < WAIT_LIMIT) begin
            if (stalled) begin
                check_value("is_en", is_en, 1'b0);
            end
            check_value("fu_en", fu_en & quiet, '0);
            step(i, '0, 1'b0);
            n++;
        end
        check_event(reg_write, "no write-back within the wait limit");
        check_value("rd", rd, exp_rd);
        check_value("write_sel", write_sel, exp_sel);
    endtask

    task automatic complete_unit(input fu_vec_t unit, input reg_idx_t exp_rd,
                                 input fu_id_t exp_sel);
        hold(NO_INST, latency(), 1'b0, '1);
        step(NO_INST, unit, 1'b0);
        wait_write(NO_INST, exp_rd, exp_sel, 1'b0, '1);
    endtask

    `include "scoreboard_tests.svh"

    initial begin
        errors  = 0;
        checks  = 0;
        rst     = 1'b1;
        inst    = NO_INST;
        fu_done = '0;
        is_jump = 1'b0;
        void'($urandom(32'h59a));
        single_issue();
        structural_stall();
        waw_stall();
        raw_wait();
        war_hold();
        jump_flush();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR at %0t ns: watchdog expired before the tests finished", $time);
        $display("Summary: %0d checks, %0d errors", checks, errors + 1);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/scoreboard_top.sv
`timescale 1ns/1ns
`default_nettype none

module scoreboard_top (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      inst,
    input  sb_pkg::fu_vec_t  fu_done,
    input  logic             is_jump,
    output logic             is_en,
    output sb_pkg::fu_vec_t  fu_en,
    output sb_pkg::op_t      op,
    output sb_pkg::reg_idx_t rs1,
    output sb_pkg::reg_idx_t rs2,
    output logic             reg_write,
    output sb_pkg::reg_idx_t rd,
    output sb_pkg::fu_id_t   write_sel
);
    import sb_pkg::*;

    logic     valid;
    logic     issue;
    logic     waw;
    fu_id_t   dec_fu;
    op_t      dec_op;
    reg_idx_t dec_dst;
    reg_idx_t dec_src1;
    reg_idx_t dec_src2;
    fu_id_t   fu1;
    fu_id_t   fu2;
    reg_idx_t release_dst;
    fu_vec_t  busy_vec;

    fu_bus_if bus ();

    inst_decoder i_decoder (
        .inst  (inst),
        .valid (valid),
        .fu    (dec_fu),
        .op    (dec_op),
        .dst   (dec_dst),
        .src1  (dec_src1),
        .src2  (dec_src2)
    );

    issue_ctrl i_issue (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .fu        (dec_fu),
        .busy_vec  (busy_vec),
        .waw       (waw),
        .jump_done (fu_done[FU_JUMP - 1]),
        .is_jump   (is_jump),
        .issue     (issue),
        .is_en     (is_en)
    );

    reg_result_status i_rrs (
        .clk         (clk),
        .rst         (rst),
        .issue       (issue),
        .dst         (dec_dst),
        .src1        (dec_src1),
        .src2        (dec_src2),
        .fu          (dec_fu),
        .release_id  (bus.release_id),
        .release_dst (release_dst),
        .fu1         (fu1),
        .fu2         (fu2),
        .waw         (waw)
    );

    // One status record per unit, numbered ALU through JUMP
    for (genvar g = 0; g < NUM_FU; g++) begin : g_entry
        fu_status_entry #(
            .FU_ID (fu_id_t'(g + 1))
        ) i_entry (
            .clk   (clk),
            .rst   (rst),
            .issue (issue),
            .fu    (dec_fu),
            .op    (dec_op),
            .dst   (dec_dst),
            .src1  (dec_src1),
            .src2  (dec_src2),
            .fu1   (fu1),
            .fu2   (fu2),
            .done  (fu_done[g]),
            .bus   (bus)
        );
    end

    fu_arbiter i_arbiter (
        .bus         (bus),
        .fu_en       (fu_en),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .reg_write   (reg_write),
        .rd          (rd),
        .write_sel   (write_sel),
        .release_dst (release_dst),
        .busy_vec    (busy_vec)
    );

endmodule

`default_nettype wire

//--- verilog/fu_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module fu_arbiter (
    fu_bus_if.arb            bus,
    output sb_pkg::fu_vec_t  fu_en,
    output sb_pkg::op_t      op,
    output sb_pkg::reg_idx_t rs1,
    output sb_pkg::reg_idx_t rs2,
    output logic             reg_write,
    output sb_pkg::reg_idx_t rd,
    output sb_pkg::fu_id_t   write_sel,
    output sb_pkg::reg_idx_t release_dst,
    output sb_pkg::fu_vec_t  busy_vec
);
    import sb_pkg::*;

    fu_vec_t ready;
    fu_vec_t war;
    fu_vec_t wb_req;
    fu_id_t  wb_id;

    // JUMP owns the top bit and wins outright, then lowest bit first
    function automatic fu_vec_t pick(input fu_vec_t req);
        if (req[FU_JUMP - 1]) begin
            return fu_vec_t'(1) << (FU_JUMP - 1);
        end
        return req & (~req + fu_vec_t'(1));
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            ready[i]   = bus.busy[i] && bus.rdy1[i] && bus.rdy2[i];
            // Someone else still has to read the old value of our dst
            war[i] = 1'b0;
            for (int j = 0; j < NUM_FU; j++) begin
                if (j != i && bus.dst[i] != '0) begin
                    war[i] = war[i]
                        || (bus.rdy1[j] && bus.src1[j] == bus.dst[i])
                        || (bus.rdy2[j] && bus.src2[j] == bus.dst[i]);
                end
            end
            wb_req[i] = bus.busy[i] && bus.done[i] && !war[i];
        end
    end

    assign bus.read_grant  = pick(ready);
    assign bus.write_grant = pick(wb_req);

    always_comb begin
        op    = '0;
        rs1   = '0;
        rs2   = '0;
        rd    = '0;
        wb_id = FU_NONE;
        for (int i = 0; i < NUM_FU; i++) begin
            if (bus.read_grant[i]) begin
                op  = bus.op[i];
                rs1 = bus.src1[i];
                rs2 = bus.src2[i];
            end
            if (bus.write_grant[i]) begin
                rd    = bus.dst[i];
                wb_id = fu_id_t'(i + 1);
            end
        end
    end

    assign bus.release_id = wb_id;
    assign fu_en          = bus.read_grant;
    assign reg_write      = |bus.write_grant;
    assign write_sel      = wb_id;
    assign release_dst    = rd;
    assign busy_vec       = bus.busy;

    // Each port serves at most one unit per cycle
    always_comb begin
        assert final ($onehot0(bus.read_grant) && $onehot0(bus.write_grant));
    end

endmodule

`default_nettype wire

//--- verilog/issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid,
    input  sb_pkg::fu_id_t  fu,
    input  sb_pkg::fu_vec_t busy_vec,
    input  logic            waw,
    input  logic            jump_done,
    input  logic            is_jump,
    output logic            issue,
    output logic            is_en
);
    import sb_pkg::*;

    fu_vec_t fu_sel;
    logic    stall;
    logic    jump_hold;
    logic    flush;

    assign fu_sel = (fu == FU_NONE) ? '0 : fu_vec_t'(1) << (fu - 3'd1);

    // Structural hazard, WAW, or an unresolved jump
    assign stall = (|(fu_sel & busy_vec)) || waw || jump_hold;
    assign issue = valid && !stall && !flush;
    // Flush cycle advances fetch but drops the instruction
    assign is_en = flush || !stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            jump_hold <= 1'b0;
            flush     <= 1'b0;
        end else begin
            if (issue && fu == FU_JUMP) begin
                jump_hold <= 1'b1;
            end else if (jump_done) begin
                jump_hold <= 1'b0;
            end
            flush <= jump_done && is_jump;
        end
    end

    // Issued unit reports busy from the next cycle
    assert property (@(posedge clk) disable iff (rst)
        issue |=> |(busy_vec & $past(fu_sel)));

endmodule

`default_nettype wire

//--- verilog/reg_result_status.sv
`timescale 1ns/1ns
`default_nettype none

module reg_result_status (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue,
    input  sb_pkg::reg_idx_t dst,
    input  sb_pkg::reg_idx_t src1,
    input  sb_pkg::reg_idx_t src2,
    input  sb_pkg::fu_id_t   fu,
    input  sb_pkg::fu_id_t   release_id,
    input  sb_pkg::reg_idx_t release_dst,
    output sb_pkg::fu_id_t   fu1,
    output sb_pkg::fu_id_t   fu2,
    output logic             waw
);
    import sb_pkg::*;

    fu_id_t rrs [32];

    // A producer writing back this cycle already counts as done
    function automatic fu_id_t live(input fu_id_t tag, input fu_id_t rel);
        return (tag == rel) ? FU_NONE : tag;
    endfunction

    assign fu1 = live(rrs[src1], release_id);
    assign fu2 = live(rrs[src2], release_id);
    assign waw = (live(rrs[dst], release_id) != FU_NONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < 32; r++) begin
                rrs[r] <= FU_NONE;
            end
        end else begin
            if (release_id != FU_NONE) begin
                rrs[release_dst] <= FU_NONE;
            end
            // After the release, so a same-cycle reuse keeps the new tag
            if (issue && dst != '0) begin
                rrs[dst] <= fu;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/fu_status_entry.sv
`timescale 1ns/1ns
`default_nettype none

module fu_status_entry #(
    parameter sb_pkg::fu_id_t FU_ID = sb_pkg::FU_ALU
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue,
    input  sb_pkg::fu_id_t   fu,
    input  sb_pkg::op_t      op,
    input  sb_pkg::reg_idx_t dst,
    input  sb_pkg::reg_idx_t src1,
    input  sb_pkg::reg_idx_t src2,
    input  sb_pkg::fu_id_t   fu1,
    input  sb_pkg::fu_id_t   fu2,
    input  logic             done,
    fu_bus_if.entry          bus
);
    import sb_pkg::*;

    localparam int IDX = FU_ID - 1;

    logic     load;
    logic     busy_q;
    logic     rdy1_q;
    logic     rdy2_q;
    logic     done_q;
    fu_id_t   fu1_q;
    fu_id_t   fu2_q;
    op_t      op_q;
    reg_idx_t dst_q;
    reg_idx_t src1_q;
    reg_idx_t src2_q;

    assign load = issue && (fu == FU_ID);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            rdy1_q <= 1'b0;
            rdy2_q <= 1'b0;
            done_q <= 1'b0;
            fu1_q  <= FU_NONE;
            fu2_q  <= FU_NONE;
        end else if (load) begin
            busy_q <= 1'b1;
            rdy1_q <= (fu1 == FU_NONE);
            rdy2_q <= (fu2 == FU_NONE);
            done_q <= 1'b0;
            fu1_q  <= fu1;
            fu2_q  <= fu2;
        end else if (bus.write_grant[IDX]) begin
            busy_q <= 1'b0;
            rdy1_q <= 1'b0;
            rdy2_q <= 1'b0;
            done_q <= 1'b0;
        end else if (busy_q) begin
            // Operands are on the read port this cycle
            if (bus.read_grant[IDX]) begin
                rdy1_q <= 1'b0;
                rdy2_q <= 1'b0;
            end
            // Producer writing back, so the operand becomes readable
            if (fu1_q != FU_NONE && fu1_q == bus.release_id) begin
                rdy1_q <= 1'b1;
                fu1_q  <= FU_NONE;
            end
            if (fu2_q != FU_NONE && fu2_q == bus.release_id) begin
                rdy2_q <= 1'b1;
                fu2_q  <= FU_NONE;
            end
            // Sticky until write-back, since WAR may hold it off
            if (done) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_q   <= op;
            dst_q  <= dst;
            src1_q <= src1;
            src2_q <= src2;
        end
    end

    assign bus.busy[IDX] = busy_q;
    assign bus.rdy1[IDX] = rdy1_q;
    assign bus.rdy2[IDX] = rdy2_q;
    assign bus.done[IDX] = done_q;
    assign bus.dst[IDX]  = dst_q;
    assign bus.src1[IDX] = src1_q;
    assign bus.src2[IDX] = src2_q;
    assign bus.fu1[IDX]  = fu1_q;
    assign bus.fu2[IDX]  = fu2_q;
    assign bus.op[IDX]   = op_q;

    // Issue control must keep a busy unit from being refilled
    assert property (@(posedge clk) disable iff (rst) load |-> !busy_q);

endmodule

`default_nettype wire

//--- verilog/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  logic [31:0]      inst,
    output logic             valid,
    output sb_pkg::fu_id_t   fu,
    output sb_pkg::op_t      op,
    output sb_pkg::reg_idx_t dst,
    output sb_pkg::reg_idx_t src1,
    output sb_pkg::reg_idx_t src2
);
    import sb_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       use_rd;
    logic       use_rs1;
    logic       use_rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        valid   = 1'b0;
        fu      = FU_NONE;
        op      = '0;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OPC_R: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                if (funct7 == 7'h01) begin
                    // M extension, funct3[2] splits MUL from DIV/REM
                    valid = 1'b1;
                    fu    = funct3[2] ? FU_DIV : FU_MUL;
                    op    = {3'b000, funct3[1:0]};
                end else if (funct7 == 7'h00 ||
                             (funct7 == 7'h20 && (funct3 == 3'h0 || funct3 == 3'h5))) begin
                    valid = 1'b1;
                    fu    = FU_ALU;
                    op    = {1'b0, funct7[5], funct3};
                end
            end
            OPC_I: begin
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
                fu      = FU_ALU;
                op      = {1'b1, funct3 == 3'h5 && funct7[5], funct3};
                // Shifts constrain funct7, the rest take any immediate
                if (funct3 == 3'h1) begin
                    valid = (funct7 == 7'h00);
                end else if (funct3 == 3'h5) begin
                    valid = (funct7 == 7'h00 || funct7 == 7'h20);
                end else begin
                    valid = 1'b1;
                end
            end
            OPC_B: begin
                valid   = (funct3[2:1] != 2'b01);
                fu      = FU_JUMP;
                op      = {2'b00, funct3};
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_L: begin
                valid   = (funct3 != 3'h3 && funct3 < 3'h6);
                fu      = FU_MEM;
                op      = {1'b0, funct3, 1'b0};
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            OPC_S: begin
                valid   = (funct3 < 3'h3);
                fu      = FU_MEM;
                op      = {1'b0, funct3, 1'b1};
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                valid  = 1'b1;
                fu     = FU_ALU;
                op     = (opcode == OPC_LUI) ? OP_ALU_LUI : OP_ALU_AUIPC;
                use_rd = 1'b1;
            end
            OPC_JAL: begin
                valid  = 1'b1;
                fu     = FU_JUMP;
                op     = OP_JUMP_JAL;
                use_rd = 1'b1;
            end
            OPC_JALR: begin
                valid   = (funct3 == 3'h0);
                fu      = FU_JUMP;
                op      = OP_JUMP_JALR;
                use_rd  = 1'b1;
                use_rs1 = 1'b1;
            end
            default: begin
                valid = 1'b0;
            end
        endcase
        if (!valid) begin
            fu = FU_NONE;
        end
    end

    // Unused fields read as x0, which never waits on anything
    assign dst  = (valid && use_rd)  ? inst[11:7]  : '0;
    assign src1 = (valid && use_rs1) ? inst[19:15] : '0;
    assign src2 = (valid && use_rs2) ? inst[24:20] : '0;

endmodule

`default_nettype wire

//--- verilog/fu_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface fu_bus_if;
    import sb_pkg::*;

    // One slot per unit, each slot driven by its own entry
    wire fu_vec_t  busy;
    wire fu_vec_t  rdy1;
    wire fu_vec_t  rdy2;
    wire fu_vec_t  done;
    wire reg_idx_t dst  [NUM_FU];
    wire reg_idx_t src1 [NUM_FU];
    wire reg_idx_t src2 [NUM_FU];
    wire fu_id_t   fu1  [NUM_FU];
    wire fu_id_t   fu2  [NUM_FU];
    wire op_t      op   [NUM_FU];

    // Shared results from the arbiter
    logic [NUM_FU-1:0] read_grant;
    logic [NUM_FU-1:0] write_grant;
    fu_id_t            release_id;

    modport entry (
        output busy, rdy1, rdy2, done, dst, src1, src2, fu1, fu2, op,
        input  read_grant, write_grant, release_id
    );

    modport arb (
        input  busy, rdy1, rdy2, done, dst, src1, src2, fu1, fu2, op,
        output read_grant, write_grant, release_id
    );

endinterface

`default_nettype wire

//--- verilog/sb_pkg.sv
`default_nettype none

package sb_pkg;

    localparam int NUM_FU = 5;

    typedef logic [2:0]        fu_id_t;
    typedef logic [4:0]        reg_idx_t;
    typedef logic [4:0]        op_t;
    typedef logic [NUM_FU-1:0] fu_vec_t;

    // Unit numbers; fu_vec_t bit (id - 1) belongs to unit id
    localparam fu_id_t FU_NONE = 3'd0;
    localparam fu_id_t FU_ALU  = 3'd1;
    localparam fu_id_t FU_MEM  = 3'd2;
    localparam fu_id_t FU_MUL  = 3'd3;
    localparam fu_id_t FU_DIV  = 3'd4;
    localparam fu_id_t FU_JUMP = 3'd5;

    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_B     = 7'b1100011;
    localparam logic [6:0] OPC_L     = 7'b0000011;
    localparam logic [6:0] OPC_S     = 7'b0100011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    // ALU ops are {use_imm, alt, funct3}
    localparam op_t OP_ALU_ADD   = 5'b00000;
    localparam op_t OP_ALU_SUB   = 5'b01000;
    localparam op_t OP_ALU_ADDI  = 5'b10000;
    localparam op_t OP_ALU_LUI   = 5'b11000;
    localparam op_t OP_ALU_AUIPC = 5'b11001;
    // MEM ops are {0, funct3, store}
    localparam op_t OP_MEM_LW    = 5'b00100;
    localparam op_t OP_MEM_SW    = 5'b00101;
    localparam op_t OP_MUL_MUL   = 5'b00000;
    localparam op_t OP_MUL_MULH  = 5'b00001;
    localparam op_t OP_DIV_DIV   = 5'b00000;
    localparam op_t OP_DIV_REM   = 5'b00010;
    // Branches carry funct3 in the low bits
    localparam op_t OP_JUMP_BEQ  = 5'b00000;
    localparam op_t OP_JUMP_JAL  = 5'b01000;
    localparam op_t OP_JUMP_JALR = 5'b01001;

endpackage

`default_nettype wire
